/* logic/exec_defines.svh */
// Execute block constants: data width, ALU operation codes, RV32I opcodes and pipeline depth.
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

`define EXEC_XLEN         32
`define ALU_OP_WIDTH      4

// alu operation codes.
`define ALU_ADD           4'h0
`define ALU_SUB           4'h1
`define ALU_XOR           4'h2
`define ALU_OR            4'h3
`define ALU_AND           4'h4
`define ALU_SLL           4'h5
`define ALU_SRL           4'h6
`define ALU_SRA           4'h7
`define ALU_SLT           4'h8
`define ALU_SLTU          4'h9

// major opcodes, instr[6:0].
`define OPC_OP            7'b0110011
`define OPC_OP_IMM        7'b0010011
`define OPC_LUI           7'b0110111
`define OPC_AUIPC         7'b0010111
`define OPC_BRANCH        7'b1100011
`define OPC_JAL           7'b1101111
`define OPC_JALR          7'b1100111

`define EXEC_PIPE_DEPTH   2         // decode register plus execute register.

`endif

/* logic/exec_pkg.sv */
// Execute block types: instruction format views, request, decoded and response records.
`default_nettype none

`include "exec_defines.svh"

package exec_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one 32-bit word, several decodings.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef enum logic [1:0] {
        CTRL_NONE   = 2'd0,
        CTRL_BRANCH = 2'd1,
        CTRL_JAL    = 2'd2,
        CTRL_JALR   = 2'd3
    } ctrl_kind_e;

    typedef struct packed {
        instr_u                instr;
        logic [`EXEC_XLEN-1:0] pc;
        logic [`EXEC_XLEN-1:0] rs1_data;
        logic [`EXEC_XLEN-1:0] rs2_data;
    } exec_req_t;

    typedef struct packed {
        logic [`ALU_OP_WIDTH-1:0] alu_op;
        logic [`EXEC_XLEN-1:0]    operand_a;
        logic [`EXEC_XLEN-1:0]    operand_b;
        logic [`EXEC_XLEN-1:0]    imm;
        logic [`EXEC_XLEN-1:0]    pc;
        logic [4:0]               rd;
        logic                     rd_write;
        ctrl_kind_e               kind;
        logic [2:0]               branch_funct3;
        logic                     illegal;
    } decoded_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0] result;
        logic [4:0]            rd;
        logic                  rd_write;
        logic                  branch_taken;
        logic [`EXEC_XLEN-1:0] target;
        logic                  illegal;
    } exec_rsp_t;

endpackage

`default_nettype wire

/* logic/carry_lookahead_adder.sv */
// Carry-lookahead adder: 4-bit lookahead groups joined by a group carry chain.
`timescale 1ns/100ps
`default_nettype none

`include "exec_defines.svh"

module carry_lookahead_adder (
    input  wire  [`EXEC_XLEN-1:0] a_i,
    input  wire  [`EXEC_XLEN-1:0] b_i,
    input  wire                   carry_in_i,
    output logic [`EXEC_XLEN-1:0] sum_o
);

    localparam int GROUP_W = 4;
    localparam int GROUPS  = `EXEC_XLEN / GROUP_W;

    logic [GROUPS-1:0] group_carry;          // carry into each group.

    assign group_carry[0] = carry_in_i;

    for (genvar k = 0; k < GROUPS; k++) begin : gen_group
        logic [GROUP_W-1:0] g;
        logic [GROUP_W-1:0] p;
        logic [GROUP_W-1:0] c;

        assign g = a_i[GROUP_W*k +: GROUP_W] & b_i[GROUP_W*k +: GROUP_W];
        assign p = a_i[GROUP_W*k +: GROUP_W] ^ b_i[GROUP_W*k +: GROUP_W];

        // carries inside the group, all from the group carry-in.
        assign c[0] = group_carry[k];
        assign c[1] = g[0] | (p[0] & c[0]);
        assign c[2] = g[1]
                    | (p[1] & g[0])
                    | (p[1] & p[0] & c[0]);
        assign c[3] = g[2]
                    | (p[2] & g[1])
                    | (p[2] & p[1] & g[0])
                    | (p[2] & p[1] & p[0] & c[0]);

        assign sum_o[GROUP_W*k +: GROUP_W] = p ^ c;

        if (k < GROUPS - 1) begin : gen_chain
            // group generate or group propagate of the incoming carry.
            assign group_carry[k+1] = g[3]
                                    | (p[3] & g[2])
                                    | (p[3] & p[2] & g[1])
                                    | (p[3] & p[2] & p[1] & g[0])
                                    | ((&p) & c[0]);
        end
    end

endmodule

`default_nettype wire

/* logic/arithmetic_logic_unit.sv */
// Arithmetic logic unit: add/sub on the lookahead adder, logic, shifts and compares.
`timescale 1ns/100ps
`default_nettype none

`include "exec_defines.svh"

module arithmetic_logic_unit (
    input  wire  [`ALU_OP_WIDTH-1:0] alu_op_i,
    input  wire  [`EXEC_XLEN-1:0]    operand_a_i,
    input  wire  [`EXEC_XLEN-1:0]    operand_b_i,
    output logic [`EXEC_XLEN-1:0]    result_o,
    output logic                     zero_o
);

    localparam int SHAMT_W = $clog2(`EXEC_XLEN);

    logic                  sub_op;
    logic [`EXEC_XLEN-1:0] adder_b;
    logic [`EXEC_XLEN-1:0] adder_sum;
    logic [SHAMT_W-1:0]    shamt;
    logic                  lt_signed;
    logic                  lt_unsigned;

    assign sub_op  = (alu_op_i == `ALU_SUB);
    assign adder_b = sub_op ? ~operand_b_i : operand_b_i;   // a + ~b + 1.
    assign shamt   = operand_b_i[SHAMT_W-1:0];

    carry_lookahead_adder adder (
        .a_i        (operand_a_i),
        .b_i        (adder_b),
        .carry_in_i (sub_op),
        .sum_o      (adder_sum)
    );

    assign lt_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
    assign lt_unsigned = (operand_a_i < operand_b_i);

    always_comb begin
        case (alu_op_i)
            `ALU_ADD,
            `ALU_SUB:  result_o = adder_sum;
            `ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
            `ALU_OR:   result_o = operand_a_i | operand_b_i;
            `ALU_AND:  result_o = operand_a_i & operand_b_i;
            `ALU_SLL:  result_o = operand_a_i << shamt;
            `ALU_SRL:  result_o = operand_a_i >> shamt;
            `ALU_SRA:  result_o = $signed(operand_a_i) >>> shamt;   // sign fill.
            `ALU_SLT:  result_o = {{(`EXEC_XLEN-1){1'b0}}, lt_signed};
            `ALU_SLTU: result_o = {{(`EXEC_XLEN-1){1'b0}}, lt_unsigned};
            default:   result_o = '0;
        endcase
    end

    assign zero_o = (result_o == '0);

endmodule

`default_nettype wire

/* logic/instruction_decoder.sv */
// Instruction decoder: maps an RV32I word to ALU op, operands, immediate and control kind.
`timescale 1ns/100ps
`default_nettype none

`include "exec_defines.svh"

module instruction_decoder (
    input  wire exec_pkg::exec_req_t req_i,
    output exec_pkg::decoded_t       decoded_o
);

    exec_pkg::instr_u      instr;
    logic [`EXEC_XLEN-1:0] imm_i;
    logic [`EXEC_XLEN-1:0] imm_b;
    logic [`EXEC_XLEN-1:0] imm_u;
    logic [`EXEC_XLEN-1:0] imm_j;
    logic                  writes_rd;

    // funct3 plus instr bit 30 to an ALU code, shared by OP and OP-IMM.
    function automatic logic [`ALU_OP_WIDTH-1:0] funct_to_alu_op(
        input logic [2:0] funct3,
        input logic       alt,
        input logic       allow_sub
    );
        logic [`ALU_OP_WIDTH-1:0] op;
        case (funct3)
            3'b000:  op = (alt && allow_sub) ? `ALU_SUB : `ALU_ADD;
            3'b001:  op = `ALU_SLL;
            3'b010:  op = `ALU_SLT;
            3'b011:  op = `ALU_SLTU;
            3'b100:  op = `ALU_XOR;
            3'b101:  op = alt ? `ALU_SRA : `ALU_SRL;
            3'b110:  op = `ALU_OR;
            default: op = `ALU_AND;
        endcase
        return op;
    endfunction

    assign instr = req_i.instr;

    // sign-extended immediates, one per format.
    assign imm_i = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
    assign imm_b = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                    instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {instr.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                    instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        decoded_o               = '0;
        decoded_o.alu_op        = `ALU_ADD;
        decoded_o.pc            = req_i.pc;
        decoded_o.rd            = instr.r_fmt.rd;
        decoded_o.kind          = exec_pkg::CTRL_NONE;
        decoded_o.branch_funct3 = instr.b_fmt.funct3;
        writes_rd               = 1'b0;

        case (instr.r_fmt.opcode)
            `OPC_OP: begin
                decoded_o.alu_op    = funct_to_alu_op(instr.r_fmt.funct3,
                                                      instr.r_fmt.funct7[5], 1'b1);
                decoded_o.operand_a = req_i.rs1_data;
                decoded_o.operand_b = req_i.rs2_data;
                writes_rd           = 1'b1;
            end
            `OPC_OP_IMM: begin
                // bit 30 selects SRAI here, never SUB.
                decoded_o.alu_op    = funct_to_alu_op(instr.i_fmt.funct3,
                                                      instr.i_fmt.imm_11_0[10], 1'b0);
                decoded_o.imm       = imm_i;
                decoded_o.operand_a = req_i.rs1_data;
                decoded_o.operand_b = imm_i;
                writes_rd           = 1'b1;
            end
            `OPC_LUI: begin
                decoded_o.imm       = imm_u;
                decoded_o.operand_b = imm_u;        // zero + imm.
                writes_rd           = 1'b1;
            end
            `OPC_AUIPC: begin
                decoded_o.imm       = imm_u;
                decoded_o.operand_a = req_i.pc;
                decoded_o.operand_b = imm_u;
                writes_rd           = 1'b1;
            end
            `OPC_BRANCH: begin
                decoded_o.kind      = exec_pkg::CTRL_BRANCH;
                decoded_o.imm       = imm_b;
                decoded_o.operand_a = req_i.rs1_data;
                decoded_o.operand_b = req_i.rs2_data;
                case (instr.b_fmt.funct3[2:1])
                    2'b10:   decoded_o.alu_op = `ALU_SLT;    // blt, bge.
                    2'b11:   decoded_o.alu_op = `ALU_SLTU;   // bltu, bgeu.
                    default: decoded_o.alu_op = `ALU_SUB;    // beq, bne.
                endcase
            end
            `OPC_JAL: begin
                decoded_o.kind      = exec_pkg::CTRL_JAL;
                decoded_o.imm       = imm_j;
                decoded_o.operand_a = req_i.pc;
                decoded_o.operand_b = imm_j;
                writes_rd           = 1'b1;
            end
            `OPC_JALR: begin
                decoded_o.kind      = exec_pkg::CTRL_JALR;
                decoded_o.imm       = imm_i;
                decoded_o.operand_a = req_i.rs1_data;   // jump base for the resolver.
                decoded_o.operand_b = imm_i;
                writes_rd           = 1'b1;
            end
            default: begin
                decoded_o.illegal   = 1'b1;
            end
        endcase

        decoded_o.rd_write = writes_rd && (instr.r_fmt.rd != 5'd0);
    end

endmodule

`default_nettype wire

/* logic/branch_resolver.sv */
// Branch resolver: taken decision, branch/jump target and the pc+4 link value.
`timescale 1ns/100ps
`default_nettype none

`include "exec_defines.svh"

module branch_resolver (
    input  wire exec_pkg::decoded_t  decoded_i,
    input  wire [`EXEC_XLEN-1:0]     alu_result_i,
    input  wire                      alu_zero_i,
    output logic                     taken_o,
    output logic [`EXEC_XLEN-1:0]    target_o,
    output logic [`EXEC_XLEN-1:0]    link_o
);

    localparam logic [`EXEC_XLEN-1:0] INSTR_BYTES = `EXEC_XLEN'(4);

    logic                  is_jalr;
    logic [`EXEC_XLEN-1:0] target_base;
    logic [`EXEC_XLEN-1:0] target_sum;

    assign is_jalr     = (decoded_i.kind == exec_pkg::CTRL_JALR);
    assign target_base = is_jalr ? decoded_i.operand_a : decoded_i.pc;   // rs1 or pc.

    carry_lookahead_adder target_adder (
        .a_i        (target_base),
        .b_i        (decoded_i.imm),
        .carry_in_i (1'b0),
        .sum_o      (target_sum)
    );

    carry_lookahead_adder link_adder (
        .a_i        (decoded_i.pc),
        .b_i        (INSTR_BYTES),
        .carry_in_i (1'b0),
        .sum_o      (link_o)
    );

    always_comb begin
        taken_o  = 1'b0;
        target_o = '0;
        case (decoded_i.kind)
            exec_pkg::CTRL_BRANCH: begin
                target_o = target_sum;
                case (decoded_i.branch_funct3)
                    3'b000:         taken_o = alu_zero_i;         // beq.
                    3'b001:         taken_o = !alu_zero_i;        // bne.
                    3'b100, 3'b110: taken_o = alu_result_i[0];    // blt, bltu.
                    3'b101, 3'b111: taken_o = !alu_result_i[0];   // bge, bgeu.
                    default:        taken_o = 1'b0;
                endcase
            end
            exec_pkg::CTRL_JAL: begin
                taken_o  = 1'b1;
                target_o = target_sum;
            end
            exec_pkg::CTRL_JALR: begin
                taken_o  = 1'b1;
                target_o = {target_sum[`EXEC_XLEN-1:1], 1'b0};
            end
            default: begin
                taken_o  = 1'b0;
                target_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
// Execute stage top: decode register, ALU and branch resolution, execute register.
`timescale 1ns/100ps
`default_nettype none

`include "exec_defines.svh"

module execute_stage (
    input  wire                       clk_i,
    input  wire                       rst_i,
    input  wire                       req_valid_i,
    input  wire exec_pkg::exec_req_t  req_i,
    output logic                      rsp_valid_o,
    output exec_pkg::exec_rsp_t       rsp_o
);

    exec_pkg::decoded_t    dec_d;
    exec_pkg::decoded_t    dec_q;
    logic                  dec_valid_q;
    logic [`EXEC_XLEN-1:0] alu_result;
    logic                  alu_zero;
    logic                  branch_taken;
    logic [`EXEC_XLEN-1:0] branch_target;
    logic [`EXEC_XLEN-1:0] link_value;
    logic                  is_jump;
    exec_pkg::exec_rsp_t   rsp_d;

    instruction_decoder decoder (
        .req_i     (req_i),
        .decoded_o (dec_d)
    );

    // decode register.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dec_valid_q <= 1'b0;
        end else begin
            dec_valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        dec_q <= dec_d;
    end

    arithmetic_logic_unit alu (
        .alu_op_i    (dec_q.alu_op),
        .operand_a_i (dec_q.operand_a),
        .operand_b_i (dec_q.operand_b),
        .result_o    (alu_result),
        .zero_o      (alu_zero)
    );

    branch_resolver resolver (
        .decoded_i    (dec_q),
        .alu_result_i (alu_result),
        .alu_zero_i   (alu_zero),
        .taken_o      (branch_taken),
        .target_o     (branch_target),
        .link_o       (link_value)
    );

    assign is_jump = (dec_q.kind == exec_pkg::CTRL_JAL) ||
                     (dec_q.kind == exec_pkg::CTRL_JALR);

    always_comb begin
        rsp_d.result       = is_jump ? link_value : alu_result;   // jumps write pc+4.
        rsp_d.rd           = dec_q.rd;
        rsp_d.rd_write     = dec_q.rd_write;
        rsp_d.branch_taken = branch_taken;
        rsp_d.target       = branch_target;
        rsp_d.illegal      = dec_q.illegal;
    end

    // execute register.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= dec_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        rsp_o <= rsp_d;
    end

endmodule

`default_nettype wire

/* verif/execute_stage_tb.sv */
// Execute stage testbench that applies a table of back-to-back requests and checks each response.
`timescale 1ns/100ps
`default_nettype none

`include "exec_defines.svh"

module execute_stage_tb;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] result;
        logic        wr;
        logic        taken;
        logic [31:0] target;
        logic        ill;
    } row_t;

    logic                clk;
    logic                rst;
    logic                req_valid;
    exec_pkg::exec_req_t req;
    logic                rsp_valid;
    exec_pkg::exec_rsp_t rsp;

    row_t rows[$];
    row_t exp_q[$];
    int   due_q[$];                 // monitor cycle at which each response is due.
    int   cycles = 0;
    int   cycle_limit;
    int   seen = 0;

    execute_stage DUT (
        .clk_i       (clk),
        .rst_i       (rst),
        .req_valid_i (req_valid),
        .req_i       (req),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3);
        exec_pkg::instr_u w;
        w.r_fmt = '{f7, 5'd2, 5'd1, f3, 5'd5, `OPC_OP};
        return w;
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [6:0] opc, input logic [4:0] rd);
        exec_pkg::instr_u w;
        w.i_fmt = '{imm, 5'd1, f3, rd, opc};
        return w;
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [2:0] f3);
        exec_pkg::instr_u w;
        w.b_fmt = '{imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], `OPC_BRANCH};
        return w;
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [6:0] opc);
        exec_pkg::instr_u w;
        w.u_fmt = '{imm, 5'd6, opc};
        return w;
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
        exec_pkg::instr_u w;
        w.j_fmt = '{imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
        return w;
    endfunction

    task automatic add_row(input logic [31:0] instr, input logic [31:0] pc,
                           input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] result, input logic wr, input logic taken,
                           input logic [31:0] target, input logic ill);
        rows.push_back('{instr, pc, a, b, result, wr, taken, target, ill});
    endtask

    task automatic stop_with_failure();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected 0x%08h, got 0x%08h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic compare_response();
        row_t exp;
        int   due;
        if (exp_q.size() == 0) begin
            $display("Response at cycle %0d with no request outstanding.", cycles);
            stop_with_failure();
        end else begin
            exp = exp_q.pop_front();
            due = due_q.pop_front();
            if (due != cycles) begin
                $display("Response at cycle %0d, but it was due at cycle %0d.", cycles, due);
                stop_with_failure();
            end else begin
                if (exp.wr || exp.instr[6:0] == `OPC_JAL || exp.instr[6:0] == `OPC_JALR) begin
                    check("rsp_o.result", exp.result, rsp.result);
                end
                check("rsp_o.rd", exp.instr[11:7], rsp.rd);
                check("rsp_o.rd_write", exp.wr, rsp.rd_write);
                check("rsp_o.branch_taken", exp.taken, rsp.branch_taken);
                check("rsp_o.target", exp.target, rsp.target);
                check("rsp_o.illegal", exp.ill, rsp.illegal);
                seen++;
            end
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
            stop_with_failure();
        end else if (rst) begin
            if (cycles > 1) begin
                check("rsp_valid_o", 32'd0, rsp_valid);
            end
        end else if (rsp_valid) begin
            compare_response();
        end else if (due_q.size() > 0 && due_q[0] <= cycles) begin
            $display("No response at cycle %0d where one was due.", due_q[0]);
            stop_with_failure();
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        void'($urandom(53707));
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;

        add_row(r_word(7'h00, 3'd0), 0, 32'h7fffffff, 1, 32'h80000000, 1, 0, 0, 0);
        add_row(r_word(7'h20, 3'd0), 0, 5, 9, 32'hfffffffc, 1, 0, 0, 0);
        add_row(i_word(12'hfff, 3'd0, `OPC_OP_IMM, 5'd5), 0, 32'h10, 0, 32'hf, 1, 0, 0, 0);
        add_row(i_word(12'h001, 3'd0, `OPC_OP_IMM, 5'd5), 0, 32'hffffffff, 0, 0, 1, 0, 0, 0);
        add_row(r_word(7'h00, 3'd4), 0, 32'ha5a5a5a5, 32'h0f0f0f0f, 32'haaaaaaaa, 1, 0, 0, 0);
        add_row(r_word(7'h00, 3'd6), 0, 32'hf0000000, 32'hf, 32'hf000000f, 1, 0, 0, 0);
        add_row(r_word(7'h00, 3'd7), 0, 32'hff00ff00, 32'h0ff00ff0, 32'h0f000f00, 1, 0, 0, 0);
        add_row(i_word(12'hfff, 3'd4, `OPC_OP_IMM, 5'd5), 0, 32'h12345678, 0, 32'hedcba987,
                1, 0, 0, 0);
        add_row(i_word(12'h0ff, 3'd7, `OPC_OP_IMM, 5'd5), 0, 32'h12345678, 0, 32'h78, 1, 0, 0, 0);
        add_row(r_word(7'h00, 3'd1), 0, 1, 32'h24, 32'h10, 1, 0, 0, 0);            // amount 4.
        add_row(r_word(7'h00, 3'd5), 0, 32'h80000000, 32'h21, 32'h40000000, 1, 0, 0, 0);
        add_row(r_word(7'h20, 3'd5), 0, 32'h80000000, 4, 32'hf8000000, 1, 0, 0, 0);
        add_row(i_word(12'h01f, 3'd1, `OPC_OP_IMM, 5'd5), 0, 3, 0, 32'h80000000, 1, 0, 0, 0);
        add_row(i_word(12'h01c, 3'd5, `OPC_OP_IMM, 5'd5), 0, 32'hf0000000, 0, 32'hf, 1, 0, 0, 0);
        add_row(i_word(12'h408, 3'd5, `OPC_OP_IMM, 5'd5), 0, 32'hf0000000, 0, 32'hfff00000,
                1, 0, 0, 0);                                                     // srai 8.
        add_row(r_word(7'h00, 3'd2), 0, 32'hffffffff, 1, 1, 1, 0, 0, 0);
        add_row(r_word(7'h00, 3'd3), 0, 32'hffffffff, 1, 0, 1, 0, 0, 0);
        add_row(i_word(12'h001, 3'd2, `OPC_OP_IMM, 5'd5), 0, 32'hffffffff, 0, 1, 1, 0, 0, 0);
        add_row(i_word(12'hfff, 3'd2, `OPC_OP_IMM, 5'd5), 0, 1, 0, 0, 1, 0, 0, 0);
        add_row(i_word(12'hfff, 3'd3, `OPC_OP_IMM, 5'd5), 0, 1, 0, 1, 1, 0, 0, 0);
        add_row(u_word(20'h12345, `OPC_LUI), 0, 0, 0, 32'h12345000, 1, 0, 0, 0);
        add_row(u_word(20'h00001, `OPC_AUIPC), 32'h100, 0, 0, 32'h1100, 1, 0, 0, 0);
        add_row(b_word(13'h0010, 3'd0), 32'h200, 5, 5, 0, 0, 1, 32'h210, 0);       // beq.
        add_row(b_word(13'h1ff8, 3'd0), 32'h200, 5, 6, 0, 0, 0, 32'h1f8, 0);
        add_row(b_word(13'h0010, 3'd1), 32'h200, 5, 6, 0, 0, 1, 32'h210, 0);       // bne.
        add_row(b_word(13'h0010, 3'd1), 32'h200, 5, 5, 0, 0, 0, 32'h210, 0);
        add_row(b_word(13'h0010, 3'd4), 32'h200, 32'hffffffff, 1, 0, 0, 1, 32'h210, 0);
        add_row(b_word(13'h0010, 3'd4), 32'h200, 1, 32'hffffffff, 0, 0, 0, 32'h210, 0);
        add_row(b_word(13'h1ff8, 3'd5), 32'h200, 1, 32'hffffffff, 0, 0, 1, 32'h1f8, 0);
        add_row(b_word(13'h0010, 3'd5), 32'h200, 32'hffffffff, 1, 0, 0, 0, 32'h210, 0);
        add_row(b_word(13'h0010, 3'd6), 32'h200, 1, 32'hffffffff, 0, 0, 1, 32'h210, 0);
        add_row(b_word(13'h0010, 3'd6), 32'h200, 32'hffffffff, 1, 0, 0, 0, 32'h210, 0);
        add_row(b_word(13'h0010, 3'd7), 32'h200, 32'hffffffff, 1, 0, 0, 1, 32'h210, 0);
        add_row(b_word(13'h1ff8, 3'd7), 32'h200, 1, 32'hffffffff, 0, 0, 0, 32'h1f8, 0);
        add_row(j_word(21'h000100, 5'd1), 32'h400, 0, 0, 32'h404, 1, 1, 32'h500, 0);
        add_row(j_word(21'h1ffffc, 5'd0), 32'h400, 0, 0, 32'h404, 0, 1, 32'h3fc, 0);
        add_row(i_word(12'h005, 3'd0, `OPC_JALR, 5'd1), 32'h80, 32'h1000, 0, 32'h84, 1, 1,
                32'h1004, 0);                                                    // bit 0 cleared.
        add_row(i_word(12'hfff, 3'd0, `OPC_JALR, 5'd2), 32'h80, 32'h2000, 0, 32'h84, 1, 1,
                32'h1ffe, 0);
        add_row(i_word(12'h000, 3'd2, 7'b0000011, 5'd3), 0, 0, 0, 0, 0, 0, 0, 1);   // load.
        add_row(32'h00000073, 0, 0, 0, 0, 0, 0, 0, 1);                             // ecall.
        for (int k = 0; k < 16; k++) begin
            a = $urandom;
            b = $urandom;
            if (k % 2 == 1) begin
                add_row(r_word(7'h20, 3'd0), 0, a, b, a - b, 1, 0, 0, 0);
            end else begin
                add_row(r_word(7'h00, 3'd0), 0, a, b, a + b, 1, 0, 0, 0);
            end
        end
        cycle_limit = 8 + rows.size() + `EXEC_PIPE_DEPTH + 20;

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (rows[i]) begin
            req_valid    = 1'b1;
            req.instr    = rows[i].instr;
            req.pc       = rows[i].pc;
            req.rs1_data = rows[i].rs1;
            req.rs2_data = rows[i].rs2;
            exp_q.push_back(rows[i]);
            due_q.push_back(cycles + 1 + `EXEC_PIPE_DEPTH);   // sampled at the next edge.
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;

        while (seen < rows.size()) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);                            // catch stray responses.
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+logic
logic/exec_pkg.sv
logic/carry_lookahead_adder.sv
logic/arithmetic_logic_unit.sv
logic/instruction_decoder.sv
logic/branch_resolver.sv
logic/execute_stage.sv
verif/execute_stage_tb.sv
